//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= mem_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- data_ram.sv
`timescale 1ns/1ps

module data_ram
  import mem_stage_pkg::*;
(
  input  logic               bus,
  input  logic               we,
  input  logic               re,
  input  logic [3:0]         be,
  input  logic [DMEM_AW-1:0] addr,
  input  logic [31:0]        din,
  output logic [31:0]        dout
);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // word array, written per byte lane
  mem_word_u mem [DMEM_WORDS];

  // write data viewed as lanes
  mem_word_u din_w;

  assign din_w.word = din;

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // each enabled lane takes its byte
  always_ff @(posedge bus) begin
    if (we) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[addr].lane[i] <= din_w.lane[i];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  // registered read, old contents on a same-edge write
  // output holds while re is low
  always_ff @(posedge bus) begin
    if (re) begin
      dout <= mem[addr].word;
    end
  end

endmodule

//--- load_extract.sv
`timescale 1ns/1ps

module load_extract
  import mem_stage_pkg::*;
(
  input  logic [4:0]  ld_ctrl,
  input  logic [1:0]  offset,
  input  logic [31:0] raw,
  output logic [31:0] result
);

  // word from the RAM and the word aligned to lane 0
  mem_word_u raw_w;
  mem_word_u algn_w;

  //////////////////////////////////////////////////////////////////////
  // alignment
  //////////////////////////////////////////////////////////////////////

  assign raw_w.word = raw;

  // rotate right by offset bytes
  // addressed byte lands in lane 0, a halfword at offset 3 wraps
  always_comb begin
    logic [1:0] src;
    algn_w.word = '0;
    for (int i = 0; i < 4; i++) begin
      src = 2'(i) + offset;
      algn_w.lane[i] = raw_w.lane[src];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // extension per load type
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ld_ctrl)
      // signed byte
      LD_LB:  result = {{24{algn_w.lane[0][7]}}, algn_w.lane[0]};
      // signed halfword
      LD_LH:  result = {{16{algn_w.lane[1][7]}}, algn_w.lane[1], algn_w.lane[0]};
      // full word
      LD_LW:  result = algn_w.word;
      // unsigned byte
      LD_LBU: result = {24'h0, algn_w.lane[0]};
      // unsigned halfword
      LD_LHU: result = {16'h0, algn_w.lane[1], algn_w.lane[0]};
      // no load or bad code reads as zero
      default: result = '0;
    endcase
  end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage
  import mem_stage_pkg::*;
(
  input  logic               bus,
  input  logic               rst_n,
  // EX/MEM side
  input  logic [31:0]        ex_mem_alures,
  input  logic [31:0]        ex_mem_dout_rs2,
  input  logic [4:0]         ex_mem_rs2,
  input  logic [4:0]         ex_mem_rd,
  input  logic               ex_mem_regwrite,
  input  logic               ex_mem_memread,
  input  logic               ex_mem_memwrite,
  input  logic [4:0]         ex_mem_ld_ctrl,
  input  logic [2:0]         ex_mem_st_ctrl,
  input  logic [31:0]        ex_mem_pres_addr,
  input  logic [31:0]        ex_mem_csr,
  input  logic               ex_mem_csr_read,
  input  logic               dbg,
  input  logic               mem_hold,
  // data RAM
  input  logic [31:0]        ram_dout,
  output logic               ram_we,
  output logic               ram_re,
  output logic [3:0]         ram_be,
  output logic [DMEM_AW-1:0] ram_addr,
  output logic [31:0]        ram_din,
  // MEM/WB side
  output logic [31:0]        mem_wb_alures,
  output logic [31:0]        mem_wb_memres,
  output logic               mem_wb_memread,
  output logic               mem_wb_regwrite,
  output logic [4:0]         mem_wb_rd,
  output logic [31:0]        mem_wb_pres_addr,
  output logic [31:0]        mem_wb_csr,
  output logic               mem_wb_csr_read,
  output logic [31:0]        wb_res
);

  // freeze of the whole stage
  logic        stall;
  // forward select and resolved store data
  logic        fwd_sel;
  logic [31:0] st_data;
  // load info carried to the aligner
  logic [4:0]  mem_wb_ld_ctrl;
  logic [1:0]  mem_wb_offset;

  //////////////////////////////////////////////////////////////////////
  // stall and store forwarding
  //////////////////////////////////////////////////////////////////////

  assign stall = dbg | mem_hold;

  // store source was written back last cycle
  // x0 never forwards
  assign fwd_sel = ex_mem_memwrite && mem_wb_regwrite &&
                   (mem_wb_rd == ex_mem_rs2) && (mem_wb_rd != 5'd0);

  assign st_data = fwd_sel ? wb_res : ex_mem_dout_rs2;

  // lane enables and rotated data for the RAM
  store_lane_align store_lane_align_inst (
    .st_ctrl   (ex_mem_st_ctrl),
    .offset    (ex_mem_alures[1:0]),
    .data      (st_data),
    .be        (ram_be),
    .lane_data (ram_din)
  );

  //////////////////////////////////////////////////////////////////////
  // RAM request
  //////////////////////////////////////////////////////////////////////

  // no access while stalled, read register holds too
  assign ram_we   = ex_mem_memwrite & ~stall;
  assign ram_re   = ex_mem_memread & ~stall;
  // word index, upper address bits ignored
  assign ram_addr = ex_mem_alures[DMEM_AW+1:2];

  //////////////////////////////////////////////////////////////////////
  // MEM/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb_alures    <= '0;
      mem_wb_memread   <= 1'b0;
      mem_wb_regwrite  <= 1'b0;
      mem_wb_rd        <= '0;
      mem_wb_pres_addr <= '0;
      mem_wb_csr       <= '0;
      mem_wb_csr_read  <= 1'b0;
      mem_wb_ld_ctrl   <= LD_NONE;
      mem_wb_offset    <= '0;
    end else if (!stall) begin
      mem_wb_alures    <= ex_mem_alures;
      mem_wb_memread   <= ex_mem_memread;
      mem_wb_regwrite  <= ex_mem_regwrite;
      mem_wb_rd        <= ex_mem_rd;
      mem_wb_pres_addr <= ex_mem_pres_addr;
      mem_wb_csr       <= ex_mem_csr;
      mem_wb_csr_read  <= ex_mem_csr_read;
      // byte offset and type, lined up with the RAM read data
      mem_wb_ld_ctrl   <= ex_mem_ld_ctrl;
      mem_wb_offset    <= ex_mem_alures[1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // load result and writeback select
  //////////////////////////////////////////////////////////////////////

  load_extract load_extract_inst (
    .ld_ctrl (mem_wb_ld_ctrl),
    .offset  (mem_wb_offset),
    .raw     (ram_dout),
    .result  (mem_wb_memres)
  );

  // csr first, then load data, then ALU result
  always_comb begin
    if (mem_wb_csr_read) begin
      wb_res = mem_wb_csr;
    end else if (mem_wb_memread) begin
      wb_res = mem_wb_memres;
    end else begin
      wb_res = mem_wb_alures;
    end
  end

endmodule

//--- mem_stage_pkg.sv
package mem_stage_pkg;

  //////////////////////////////////////////////////////////////////////
  // data memory geometry
  //////////////////////////////////////////////////////////////////////

  // number of 32-bit words in the data RAM
  localparam int DMEM_WORDS = 256;
  // word index width, taken from alures[9:2]
  localparam int DMEM_AW = 8;

  //////////////////////////////////////////////////////////////////////
  // load / store control encodings
  //////////////////////////////////////////////////////////////////////

  // load type, one-hot
  localparam logic [4:0] LD_NONE = 5'b00000;
  localparam logic [4:0] LD_LB   = 5'b00001;
  localparam logic [4:0] LD_LH   = 5'b00010;
  localparam logic [4:0] LD_LW   = 5'b00100;
  localparam logic [4:0] LD_LBU  = 5'b01000;
  localparam logic [4:0] LD_LHU  = 5'b10000;

  // store type, one-hot
  localparam logic [2:0] ST_NONE = 3'b000;
  localparam logic [2:0] ST_SB   = 3'b001;
  localparam logic [2:0] ST_SH   = 3'b010;
  localparam logic [2:0] ST_SW   = 3'b100;

  // all four lanes enabled
  localparam logic [3:0] BE_ALL = 4'b1111;

  // one memory word, seen whole or as four byte lanes
  // lane 0 is bits 7:0
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] lane;
  } mem_word_u;

endpackage

//--- mem_subsys.f
mem_stage_pkg.sv
store_lane_align.sv
load_extract.sv
data_ram.sv
mem_stage.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top
  import mem_stage_pkg::*;
(
  input  logic        bus,
  input  logic        rst_n,
  // EX/MEM side
  input  logic [31:0] ex_mem_alures,
  input  logic [31:0] ex_mem_dout_rs2,
  input  logic [4:0]  ex_mem_rs2,
  input  logic [4:0]  ex_mem_rd,
  input  logic        ex_mem_regwrite,
  input  logic        ex_mem_memread,
  input  logic        ex_mem_memwrite,
  input  logic [4:0]  ex_mem_ld_ctrl,
  input  logic [2:0]  ex_mem_st_ctrl,
  input  logic [31:0] ex_mem_pres_addr,
  input  logic [31:0] ex_mem_csr,
  input  logic        ex_mem_csr_read,
  input  logic        dbg,
  input  logic        mem_hold,
  // MEM/WB side
  output logic [31:0] mem_wb_alures,
  output logic [31:0] mem_wb_memres,
  output logic        mem_wb_memread,
  output logic        mem_wb_regwrite,
  output logic [4:0]  mem_wb_rd,
  output logic [31:0] mem_wb_pres_addr,
  output logic [31:0] mem_wb_csr,
  output logic        mem_wb_csr_read,
  output logic [31:0] wb_res
);

  // stage to RAM
  logic               ram_we;
  logic               ram_re;
  logic [3:0]         ram_be;
  logic [DMEM_AW-1:0] ram_addr;
  logic [31:0]        ram_din;
  // RAM to stage, registered
  logic [31:0]        ram_dout;

  mem_stage mem_stage_inst (
    .bus              (bus),
    .rst_n            (rst_n),
    .ex_mem_alures    (ex_mem_alures),
    .ex_mem_dout_rs2  (ex_mem_dout_rs2),
    .ex_mem_rs2       (ex_mem_rs2),
    .ex_mem_rd        (ex_mem_rd),
    .ex_mem_regwrite  (ex_mem_regwrite),
    .ex_mem_memread   (ex_mem_memread),
    .ex_mem_memwrite  (ex_mem_memwrite),
    .ex_mem_ld_ctrl   (ex_mem_ld_ctrl),
    .ex_mem_st_ctrl   (ex_mem_st_ctrl),
    .ex_mem_pres_addr (ex_mem_pres_addr),
    .ex_mem_csr       (ex_mem_csr),
    .ex_mem_csr_read  (ex_mem_csr_read),
    .dbg              (dbg),
    .mem_hold         (mem_hold),
    .ram_dout         (ram_dout),
    .ram_we           (ram_we),
    .ram_re           (ram_re),
    .ram_be           (ram_be),
    .ram_addr         (ram_addr),
    .ram_din          (ram_din),
    .mem_wb_alures    (mem_wb_alures),
    .mem_wb_memres    (mem_wb_memres),
    .mem_wb_memread   (mem_wb_memread),
    .mem_wb_regwrite  (mem_wb_regwrite),
    .mem_wb_rd        (mem_wb_rd),
    .mem_wb_pres_addr (mem_wb_pres_addr),
    .mem_wb_csr       (mem_wb_csr),
    .mem_wb_csr_read  (mem_wb_csr_read),
    .wb_res           (wb_res)
  );

  // byte-enabled data memory
  data_ram data_ram_inst (
    .bus  (bus),
    .we   (ram_we),
    .re   (ram_re),
    .be   (ram_be),
    .addr (ram_addr),
    .din  (ram_din),
    .dout (ram_dout)
  );

endmodule

//--- store_lane_align.sv
`timescale 1ns/1ps

module store_lane_align
  import mem_stage_pkg::*;
(
  input  logic [2:0]  st_ctrl,
  input  logic [1:0]  offset,
  input  logic [31:0] data,
  output logic [3:0]  be,
  output logic [31:0] lane_data
);

  // store data before and after the lane rotation
  mem_word_u src_w;
  mem_word_u rot_w;

  // enable pattern doubled so a shift acts as a 4-bit rotate
  logic [3:0] be_pat;
  logic [7:0] be_dbl;

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (st_ctrl)
      // single byte, one lane
      ST_SB: be_pat = 4'b0001;
      // halfword, two adjacent lanes
      ST_SH: be_pat = 4'b0011;
      // word store, no store and illegal codes
      default: be_pat = BE_ALL;
    endcase
  end

  // rotate left by offset
  // sh at offset 3 wraps into lane 0, giving 1001
  assign be_dbl = {be_pat, be_pat} << offset;
  assign be     = be_dbl[7:4];

  //////////////////////////////////////////////////////////////////////
  // data lanes
  //////////////////////////////////////////////////////////////////////

  assign src_w.word = data;

  // byte i of the store data moves to lane i + offset, modulo 4
  always_comb begin
    logic [1:0] dst;
    rot_w.word = '0;
    for (int i = 0; i < 4; i++) begin
      dst = 2'(i) + offset;
      rot_w.lane[dst] = src_w.lane[i];
    end
  end

  // byte 0 now sits in the first enabled lane
  assign lane_data = rot_w.word;

endmodule

//--- tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys
  import mem_stage_pkg::*;
();

  localparam int         HALF_PERIOD = 20;
  localparam int         WAIT_LIMIT  = 16;
  localparam int         N_RANDOM    = 200;
  // small word window so loads hit stored data
  localparam logic [7:0] WIN_BASE    = 8'd4;

  logic        bus;
  logic        rst_n;
  logic [31:0] ex_mem_alures;
  logic [31:0] ex_mem_dout_rs2;
  logic [4:0]  ex_mem_rs2;
  logic [4:0]  ex_mem_rd;
  logic        ex_mem_regwrite;
  logic        ex_mem_memread;
  logic        ex_mem_memwrite;
  logic [4:0]  ex_mem_ld_ctrl;
  logic [2:0]  ex_mem_st_ctrl;
  logic [31:0] ex_mem_pres_addr;
  logic [31:0] ex_mem_csr;
  logic        ex_mem_csr_read;
  logic        dbg;
  logic        mem_hold;
  logic [31:0] mem_wb_alures;
  logic [31:0] mem_wb_memres;
  logic        mem_wb_memread;
  logic        mem_wb_regwrite;
  logic [4:0]  mem_wb_rd;
  logic [31:0] mem_wb_pres_addr;
  logic [31:0] mem_wb_csr;
  logic        mem_wb_csr_read;
  logic [31:0] wb_res;

  // model memory, valid once a full word was stored
  logic [31:0] model_mem [DMEM_WORDS];
  logic        model_valid [DMEM_WORDS];
  // model of the registered RAM read word
  logic [31:0] model_raw;
  // read word came from a word written in full
  logic        raw_valid;
  // shadow of the MEM/WB register
  logic [31:0] exp_alures;
  logic [31:0] exp_pres_addr;
  logic [31:0] exp_csr;
  logic        exp_memread;
  logic        exp_regwrite;
  logic        exp_csr_read;
  logic [4:0]  exp_rd;
  logic [4:0]  exp_ld_ctrl;
  logic [1:0]  exp_offset;

  int          errors;
  int          checks;
  // count of edges where the stage took its inputs
  int          accepted;
  logic [31:0] lfsr_state;

  mem_subsys_top mem_subsys_top_inst (.*);

  initial begin
    bus = 1'b0;
    forever begin
      #(HALF_PERIOD) bus = ~bus;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // random source and reference rules
  ////////////////////////////////////////////////////////////////////

  // fibonacci form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one step per bit taken
  task automatic draw(input int nbits, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [2:0] st_code(input int k);
    return 3'(1 << k);
  endfunction

  function automatic logic [4:0] ld_code(input int k);
    return 5'(1 << k);
  endfunction

  // expected load result: rotate right by offset bytes, then extend
  function automatic logic [31:0] ref_load(input logic [31:0] word, input logic [4:0] ld,
                                           input logic [1:0] off);
    logic [63:0] dbl;
    logic [31:0] al;
    dbl = {word, word} >> (8 * off);
    al  = dbl[31:0];
    case (ld)
      LD_LB:   return 32'($signed(al[7:0]));
      LD_LH:   return 32'($signed(al[15:0]));
      LD_LW:   return al;
      LD_LBU:  return {24'd0, al[7:0]};
      LD_LHU:  return {16'd0, al[15:0]};
      default: return 32'd0;
    endcase
  endfunction

  // priority csr, load data, ALU result
  function automatic logic [31:0] expect_wb();
    if (exp_csr_read) begin
      return exp_csr;
    end else if (exp_memread) begin
      return ref_load(model_raw, exp_ld_ctrl, exp_offset);
    end
    return exp_alures;
  endfunction

  // byte b of the data goes to lane off + b, wrapping in the word
  task automatic model_store(input logic [7:0] idx, input logic [1:0] off,
                             input logic [2:0] st, input logic [31:0] data);
    logic [1:0]  lane;
    logic [31:0] w;
    int          nbytes;
    nbytes = (st == ST_SB) ? 1 : (st == ST_SH) ? 2 : 4;
    w = model_mem[idx];
    for (int b = 0; b < nbytes; b++) begin
      lane = off + 2'(b);
      w[8*lane +: 8] = data[8*b +: 8];
    end
    model_mem[idx] = w;
    if (nbytes == 4) begin
      model_valid[idx] = 1'b1;
    end
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////////////

  // model steps on unstalled edges, outputs compared every cycle
  // so held values during a stall get checked as well
  initial begin
    logic [31:0] st_src;
    logic [7:0]  idx;
    forever begin
      @(posedge bus);
      if (!rst_n) begin
        exp_alures    = '0;
        exp_pres_addr = '0;
        exp_csr       = '0;
        exp_memread   = 1'b0;
        exp_regwrite  = 1'b0;
        exp_csr_read  = 1'b0;
        exp_rd        = '0;
        exp_ld_ctrl   = LD_NONE;
        exp_offset    = '0;
      end else if (!(dbg || mem_hold)) begin
        idx = ex_mem_alures[9:2];
        // forwarding source is the writeback value before this edge
        if (exp_regwrite && (exp_rd == ex_mem_rs2) && (exp_rd != 5'd0)) begin
          st_src = expect_wb();
        end else begin
          st_src = ex_mem_dout_rs2;
        end
        // read sees the old word
        if (ex_mem_memread) begin
          model_raw = model_mem[idx];
          raw_valid = model_valid[idx];
        end
        if (ex_mem_memwrite) begin
          model_store(idx, ex_mem_alures[1:0], ex_mem_st_ctrl, st_src);
        end
        exp_alures    = ex_mem_alures;
        exp_pres_addr = ex_mem_pres_addr;
        exp_csr       = ex_mem_csr;
        exp_memread   = ex_mem_memread;
        exp_regwrite  = ex_mem_regwrite;
        exp_csr_read  = ex_mem_csr_read;
        exp_rd        = ex_mem_rd;
        exp_ld_ctrl   = ex_mem_ld_ctrl;
        exp_offset    = ex_mem_alures[1:0];
        accepted++;
      end
      @(negedge bus);
      if (rst_n) begin
        check("mem_wb_alures", exp_alures, mem_wb_alures);
        check("mem_wb_pres_addr", exp_pres_addr, mem_wb_pres_addr);
        check("mem_wb_csr", exp_csr, mem_wb_csr);
        check("mem_wb_memread", 32'(exp_memread), 32'(mem_wb_memread));
        check("mem_wb_regwrite", 32'(exp_regwrite), 32'(mem_wb_regwrite));
        check("mem_wb_csr_read", 32'(exp_csr_read), 32'(mem_wb_csr_read));
        check("mem_wb_rd", 32'(exp_rd), 32'(mem_wb_rd));
        // load data only known for words written in full
        if (raw_valid || !exp_memread) begin
          check("mem_wb_memres", ref_load(model_raw, exp_ld_ctrl, exp_offset), mem_wb_memres);
          check("wb_res", expect_wb(), wb_res);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////

  task automatic drive_idle();
    ex_mem_alures    = '0;
    ex_mem_dout_rs2  = '0;
    ex_mem_rs2       = '0;
    ex_mem_rd        = '0;
    ex_mem_regwrite  = 1'b0;
    ex_mem_memread   = 1'b0;
    ex_mem_memwrite  = 1'b0;
    ex_mem_ld_ctrl   = LD_NONE;
    ex_mem_st_ctrl   = ST_NONE;
    ex_mem_pres_addr = '0;
    ex_mem_csr       = '0;
    ex_mem_csr_read  = 1'b0;
    dbg              = 1'b0;
    mem_hold         = 1'b0;
  endtask

  // random upper address bits, which the RAM ignores
  task automatic fill_common(input logic [7:0] idx, input logic [1:0] off);
    logic [31:0] r;
    drive_idle();
    draw(22, r);
    ex_mem_alures = {r[21:0], idx, off};
    draw(32, r);
    ex_mem_pres_addr = r;
    draw(32, r);
    ex_mem_csr = r;
  endtask

  task automatic put_store(input logic [7:0] idx, input logic [1:0] off, input logic [2:0] st,
                           input logic [4:0] rs2, input logic [31:0] data);
    fill_common(idx, off);
    ex_mem_memwrite = 1'b1;
    ex_mem_st_ctrl  = st;
    ex_mem_rs2      = rs2;
    ex_mem_dout_rs2 = data;
  endtask

  task automatic put_load(input logic [7:0] idx, input logic [1:0] off, input logic [4:0] ld,
                          input logic [4:0] rd);
    fill_common(idx, off);
    ex_mem_memread  = 1'b1;
    ex_mem_regwrite = 1'b1;
    ex_mem_ld_ctrl  = ld;
    ex_mem_rd       = rd;
  endtask

  task automatic put_alu(input logic [4:0] rd, input logic [31:0] res);
    fill_common(8'd0, 2'd0);
    ex_mem_alures   = res;
    ex_mem_regwrite = 1'b1;
    ex_mem_rd       = rd;
  endtask

  // wait until the stage has taken the driven inputs
  task automatic step();
    int target;
    target = accepted + 1;
    for (int n = 0; n < WAIT_LIMIT; n++) begin
      @(negedge bus);
      if (accepted >= target) begin
        return;
      end
    end
    errors++;
    $display("timeout: the stage did not take an operation within %0d cycles", WAIT_LIMIT);
    finish_run();
  endtask

  ////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] data;
    logic [2:0]  kind;
    logic [2:0]  sel;
    logic [2:0]  rg;
    logic [7:0]  idx;
    errors     = 0;
    checks     = 0;
    accepted   = 0;
    lfsr_state = 32'h54d6_e26f;
    model_raw  = '0;
    raw_valid  = 1'b0;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      model_valid[i] = 1'b0;
    end
    rst_n = 1'b0;
    drive_idle();
    // reset held over three edges
    for (int n = 0; n < 3; n++) begin
      @(negedge bus);
    end
    check("mem_wb_regwrite", 32'd0, 32'(mem_wb_regwrite));
    check("mem_wb_memread", 32'd0, 32'(mem_wb_memread));
    check("mem_wb_csr_read", 32'd0, 32'(mem_wb_csr_read));
    rst_n = 1'b1;

    // full words into the window
    for (int w = 0; w < 4; w++) begin
      draw(32, r);
      put_store(WIN_BASE + 8'(w), 2'd0, ST_SW, 5'd0, r);
      step();
    end

    // every store size at every offset, then every load at every offset
    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 4; o++) begin
        draw(32, r);
        // odd offsets get sign bits set in every byte
        data = (o % 2 == 1) ? (r | 32'h8080_8080) : (r & 32'h7f7f_7f7f);
        put_store(WIN_BASE, 2'(o), st_code(s), 5'd0, data);
        step();
        for (int l = 0; l < 5; l++) begin
          for (int lo = 0; lo < 4; lo++) begin
            put_load(WIN_BASE, 2'(lo), ld_code(l), 5'd3);
            step();
          end
        end
      end
    end

    // store data forwarded from an ALU result, then from a load
    put_alu(5'd5, 32'hcafe_0123);
    step();
    put_store(WIN_BASE + 8'd1, 2'd0, ST_SW, 5'd5, 32'h1111_1111);
    step();
    put_load(WIN_BASE + 8'd1, 2'd0, LD_LW, 5'd6);
    step();
    put_store(WIN_BASE + 8'd2, 2'd1, ST_SH, 5'd6, 32'h2222_2222);
    step();
    put_load(WIN_BASE + 8'd2, 2'd0, LD_LW, 5'd0);
    step();
    // x0 never forwards
    put_alu(5'd0, 32'h3333_3333);
    step();
    put_store(WIN_BASE + 8'd3, 2'd0, ST_SW, 5'd0, 32'h4444_4444);
    step();
    put_load(WIN_BASE + 8'd3, 2'd0, LD_LW, 5'd1);
    step();

    // store held under dbg and then mem_hold must not land
    put_store(WIN_BASE + 8'd3, 2'd0, ST_SW, 5'd0, 32'hdead_beef);
    dbg = 1'b1;
    for (int n = 0; n < 4; n++) begin
      @(negedge bus);
    end
    dbg      = 1'b0;
    mem_hold = 1'b1;
    for (int n = 0; n < 3; n++) begin
      @(negedge bus);
    end
    put_load(WIN_BASE + 8'd3, 2'd0, LD_LW, 5'd2);
    step();

    // random mix of stores, loads, ALU and csr reads
    for (int n = 0; n < N_RANDOM; n++) begin
      draw(3, r);
      kind = r[2:0];
      draw(2, r);
      idx = WIN_BASE + 8'(r[1:0]);
      draw(3, r);
      sel = r[2:0];
      draw(3, r);
      rg = r[2:0];
      draw(32, data);
      case (kind)
        3'd0, 3'd1, 3'd2: put_store(idx, data[5:4], st_code(int'(sel) % 3), 5'(rg), data);
        3'd3, 3'd4, 3'd5: put_load(idx, data[5:4], ld_code(int'(sel) % 5), 5'(rg));
        3'd6: put_alu(5'(rg), data);
        default: begin
          fill_common(idx, data[5:4]);
          ex_mem_csr_read = 1'b1;
          ex_mem_regwrite = 1'b1;
          ex_mem_rd       = 5'(rg);
          // a load beside the csr read, csr still wins
          if (data[0]) begin
            ex_mem_memread = 1'b1;
            ex_mem_ld_ctrl = LD_LW;
          end
        end
      endcase
      step();
    end

    drive_idle();
    step();
    // let the last compare finish
    for (int n = 0; n < 2; n++) begin
      @(posedge bus);
    end
    finish_run();
  end

endmodule
